/* hw/fetch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// fetch alignment package
// widths, word buffer sizing, aligner states and the instruction
// records handed from aligner to expander and out to decode
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // basic data widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned HLEN = 16;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [HLEN-1:0] half_t;
  typedef logic [XLEN-1:0] addr_t;

  // word buffer sizing
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  // count runs 0..FIFO_DEPTH inclusive
  typedef logic [CNT_W-1:0] cnt_t;

  //////////////////////////////////////////////////////////////////////
  // instruction encoding fields
  //////////////////////////////////////////////////////////////////////

  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [11:0] imm12_t;

  // low two bits of a parcel, 11 starts a 32-bit instruction
  localparam logic [1:0] LEN32_MARK = 2'b11;

  // 32-bit target encodings
  localparam opcode_t  OPC_OP_IMM = 7'b0010011;
  localparam opcode_t  OPC_OP     = 7'b0110011;
  localparam funct3_t  F3_ADD     = 3'b000;
  localparam funct7_t  F7_ADD     = 7'b0000000;
  localparam reg_idx_t REG_X0     = 5'd0;

  // compressed quadrants and funct3 values
  localparam logic [1:0] RVC_Q1       = 2'b01;
  localparam logic [1:0] RVC_Q2       = 2'b10;
  localparam funct3_t    RVC_F3_ADDI  = 3'b000;
  localparam funct3_t    RVC_F3_LI    = 3'b010;
  localparam funct3_t    RVC_F3_MVADD = 3'b100;

  // aligner state machine
  typedef enum logic [2:0] {
    ALIGNED32,
    ALIGNED16,
    MISALIGNED32,
    MISALIGNED16,
    BRANCH_MISALIGNED
  } align_state_e;

  // aligner output, upper half zero for compressed
  typedef struct packed {
    word_t instr;
    addr_t pc;
    logic  compressed;
  } raw_instr_t;

  // expanded instruction toward decode
  typedef struct packed {
    word_t instr;
    addr_t pc;
    logic  compressed;
    logic  illegal;
  } instr_out_t;

endpackage

/* hw/fetch_fifo.sv */
//////////////////////////////////////////////////////////////////////
// fetch word buffer
// small circular FIFO of memory words in front of the aligner,
// emptied on a branch, full level used as the fetch stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_fifo (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             push_i,
  input  fetch_pkg::word_t push_data_i,
  input  logic             pop_i,
  output logic             head_valid_o,
  output fetch_pkg::word_t head_word_o,
  output logic             full_o
);

  import fetch_pkg::*;

  // storage, payload only
  word_t mem_q [FIFO_DEPTH];

  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  cnt_q;

  logic  push_ok;
  logic  pop_ok;

  // wrap a pointer at the end of the array
  function automatic ptr_t ptr_inc(input ptr_t p);
    if (p == ptr_t'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // status and head
  //////////////////////////////////////////////////////////////////////

  assign full_o       = (cnt_q == cnt_t'(FIFO_DEPTH));
  assign head_valid_o = (cnt_q != '0);
  assign head_word_o  = mem_q[rd_ptr_q];

  // a word strobed while full is lost
  assign push_ok = push_i & ~full_o;
  // popping an empty buffer does nothing
  assign pop_ok  = pop_i & head_valid_o;

  //////////////////////////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // flush beats any push or pop this cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leave the count alone
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (push_ok && !flush_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* hw/instr_aligner.sv */
//////////////////////////////////////////////////////////////////////
// instruction aligner
// cuts the buffered word stream into 16/32-bit instructions,
// keeps the spare upper halfword and tracks the pc
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instr_aligner (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  head_valid_i,
  input  fetch_pkg::word_t      head_word_i,
  output logic                  pop_o,
  input  logic                  id_valid_i,
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,
  output logic                  raw_valid_o,
  output fetch_pkg::raw_instr_t raw_o
);

  import fetch_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  addr_t        pc_q;
  addr_t        pc_n;

  // upper half of the last popped word
  half_t        stored_q;

  half_t        head_lo;
  half_t        head_hi;

  word_t        instr_c;
  logic         compressed_c;
  logic         valid_c;
  // head word fully used once this instruction retires
  logic         consume_c;
  // misaligned branch target starting a 32-bit instruction
  logic         discard_c;

  logic         fire;
  logic         advance;

  assign head_lo = head_word_i[15:0];
  assign head_hi = head_word_i[31:16];

  //////////////////////////////////////////////////////////////////////
  // next instruction selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n      = state_q;
    pc_n         = pc_q;
    instr_c      = head_word_i;
    compressed_c = 1'b0;
    valid_c      = 1'b0;
    consume_c    = 1'b0;
    discard_c    = 1'b0;

    case (state_q)
      // next instruction starts at the low half of the head word
      ALIGNED32, MISALIGNED16: begin
        valid_c   = head_valid_i;
        consume_c = 1'b1;
        if (head_lo[1:0] == LEN32_MARK) begin
          state_n = ALIGNED32;
          pc_n    = pc_q + addr_t'(4);
          instr_c = head_word_i;
        end else begin
          // upper half moves into the stored halfword
          state_n      = ALIGNED16;
          pc_n         = pc_q + addr_t'(2);
          instr_c      = {16'b0, head_lo};
          compressed_c = 1'b1;
        end
      end

      // next instruction starts in the stored halfword
      ALIGNED16, MISALIGNED32: begin
        if (stored_q[1:0] == LEN32_MARK) begin
          // straddles into the head word
          valid_c   = head_valid_i;
          consume_c = 1'b1;
          state_n   = MISALIGNED32;
          pc_n      = pc_q + addr_t'(4);
          instr_c   = {head_lo, stored_q};
        end else begin
          // complete on its own, head word stays put
          valid_c      = 1'b1;
          consume_c    = 1'b0;
          state_n      = MISALIGNED16;
          pc_n         = pc_q + addr_t'(2);
          instr_c      = {16'b0, stored_q};
          compressed_c = 1'b1;
        end
      end

      // target has bit 1 set, low half of first word is skipped
      BRANCH_MISALIGNED: begin
        consume_c = 1'b1;
        if (head_hi[1:0] == LEN32_MARK) begin
          // keep the upper half and wait for the next word
          discard_c = head_valid_i;
          state_n   = MISALIGNED32;
        end else begin
          valid_c      = head_valid_i;
          state_n      = ALIGNED32;
          pc_n         = pc_q + addr_t'(2);
          instr_c      = {16'b0, head_hi};
          compressed_c = 1'b1;
        end
      end

      default: begin
        state_n = ALIGNED32;
      end
    endcase
  end

  // decode takes the instruction at this edge
  assign fire    = valid_c & id_valid_i;
  assign advance = fire | discard_c;

  // nothing leaves and nothing is popped in a branch cycle
  assign raw_valid_o = valid_c & ~branch_i;
  assign pop_o       = advance & consume_c & ~branch_i;

  assign raw_o = '{instr: instr_c, pc: pc_q, compressed: compressed_c};

  //////////////////////////////////////////////////////////////////////
  // state and pc
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED32;
      pc_q    <= '0;
    end else if (branch_i) begin
      pc_q    <= branch_addr_i;
      state_q <= branch_addr_i[1] ? BRANCH_MISALIGNED : ALIGNED32;
    end else if (advance) begin
      pc_q    <= pc_n;
      state_q <= state_n;
    end
  end

  // spare halfword, refreshed on every pop
  always_ff @(posedge clk) begin
    if (pop_o) begin
      stored_q <= head_hi;
    end
  end

endmodule

/* hw/rvc_expander.sv */
//////////////////////////////////////////////////////////////////////
// compressed instruction expander
// rebuilds C.NOP, C.ADDI, C.LI, C.MV and C.ADD as 32-bit
// instructions, flags every other compressed encoding
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rvc_expander (
  input  fetch_pkg::raw_instr_t raw_i,
  output fetch_pkg::instr_out_t out_o
);

  import fetch_pkg::*;

  // compressed parcel and its fields
  half_t    c_instr;
  logic [1:0] quad;
  funct3_t  c_funct3;
  reg_idx_t rd;
  reg_idx_t rs2;
  imm12_t   imm;

  // decoded compressed forms
  logic     is_addi;
  logic     is_li;
  logic     is_mv;
  logic     is_add;
  logic     supported;

  word_t    exp_instr;

  assign c_instr  = raw_i.instr[HLEN-1:0];
  assign quad     = c_instr[1:0];
  assign c_funct3 = c_instr[15:13];
  assign rd       = c_instr[11:7];
  assign rs2      = c_instr[6:2];

  // 6-bit immediate, sign bit in position 12
  assign imm = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};

  //////////////////////////////////////////////////////////////////////
  // compressed decode
  //////////////////////////////////////////////////////////////////////

  // c.addi, c.nop is the rd=0 imm=0 case of the same form
  assign is_addi = (quad == RVC_Q1) && (c_funct3 == RVC_F3_ADDI);

  // c.li
  assign is_li = (quad == RVC_Q1) && (c_funct3 == RVC_F3_LI);

  // c.mv, rs2 of zero would be c.jr
  assign is_mv = (quad == RVC_Q2) && (c_funct3 == RVC_F3_MVADD) &&
                 !c_instr[12] && (rs2 != REG_X0);

  // c.add, rs2 of zero would be c.jalr or c.ebreak
  assign is_add = (quad == RVC_Q2) && (c_funct3 == RVC_F3_MVADD) &&
                  c_instr[12] && (rs2 != REG_X0);

  assign supported = is_addi | is_li | is_mv | is_add;

  //////////////////////////////////////////////////////////////////////
  // 32-bit rebuild
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // unsupported parcels stay zero-extended
    exp_instr = raw_i.instr;
    if (is_addi) begin
      // addi rd, rd, imm
      exp_instr = {imm, rd, F3_ADD, rd, OPC_OP_IMM};
    end else if (is_li) begin
      // addi rd, x0, imm
      exp_instr = {imm, REG_X0, F3_ADD, rd, OPC_OP_IMM};
    end else if (is_mv) begin
      // add rd, x0, rs2
      exp_instr = {F7_ADD, rs2, REG_X0, F3_ADD, rd, OPC_OP};
    end else if (is_add) begin
      // add rd, rd, rs2
      exp_instr = {F7_ADD, rs2, rd, F3_ADD, rd, OPC_OP};
    end
  end

  // full-size instructions pass straight through
  always_comb begin
    out_o.pc         = raw_i.pc;
    out_o.compressed = raw_i.compressed;
    if (raw_i.compressed) begin
      out_o.instr   = exp_instr;
      out_o.illegal = ~supported;
    end else begin
      out_o.instr   = raw_i.instr;
      out_o.illegal = 1'b0;
    end
  end

endmodule

/* hw/fetch_align_top.sv */
//////////////////////////////////////////////////////////////////////
// fetch alignment top
// chain of word buffer, aligner and compressed expander
// between instruction memory and decode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_align_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_valid_i,
  input  fetch_pkg::word_t      mem_data_i,
  output logic                  fetch_stall_o,
  input  logic                  id_valid_i,
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,
  output logic                  instr_valid_o,
  output fetch_pkg::instr_out_t instr_o
);

  import fetch_pkg::*;

  // buffer to aligner
  logic       head_valid;
  word_t      head_word;
  logic       pop;

  // aligner to expander
  raw_instr_t raw;

  // words from memory, flushed by a branch
  fetch_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (branch_i),
    .push_i       (mem_valid_i),
    .push_data_i  (mem_data_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_word_o  (head_word),
    .full_o       (fetch_stall_o)
  );

  // aligner valid is the top-level valid
  instr_aligner u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_valid_i  (head_valid),
    .head_word_i   (head_word),
    .pop_o         (pop),
    .id_valid_i    (id_valid_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .raw_valid_o   (instr_valid_o),
    .raw_o         (raw)
  );

  rvc_expander u_expander (
    .raw_i (raw),
    .out_o (instr_o)
  );

endmodule

/* tests/tb_fetch_align.sv */
//////////////////////////////////////////////////////////////////////
// fetch alignment testbench
// random memory image streamed into the DUT, reference model walks
// the same halfword stream and predicts every accepted instruction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_fetch_align;

  import fetch_pkg::*;

  localparam int IMG_WORDS = 64;

  logic       clk;
  logic       rst_n;
  logic       mem_valid_i;
  word_t      mem_data_i;
  logic       fetch_stall_o;
  logic       id_valid_i;
  logic       branch_i;
  addr_t      branch_addr_i;
  logic       instr_valid_o;
  instr_out_t instr_o;

  word_t      image [IMG_WORDS];
  logic [31:0] lfsr;
  // next word address the memory side will deliver
  addr_t      fetch_addr;
  addr_t      model_pc;
  addr_t      branch_tgt;
  logic       branch_req;
  logic       run_mem;
  // 0 decode always ready, 1 random, 2 held low
  logic [1:0] bp_mode;
  logic       stall_s;
  // buffer fill is tracked while the stream runs without branches
  logic       fill_check;
  logic       prev_hold;
  instr_out_t prev_out;
  int         accepted;
  int         n_legal;
  int         n_illegal;
  string      test_name;

  fetch_align_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_valid_i   (mem_valid_i),
    .mem_data_i    (mem_data_i),
    .fetch_stall_o (fetch_stall_o),
    .id_valid_i    (id_valid_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // image wraps every 256 bytes
  function automatic half_t half_at(input addr_t a);
    word_t w;
    w = image[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // 32-bit form of a compressed parcel, bit 32 set when unsupported
  function automatic logic [32:0] expand(input half_t c);
    logic [11:0] imm;
    imm = {{7{c[12]}}, c[6:2]};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
      return {1'b0, imm, c[11:7], 3'b000, c[11:7], 7'h13};
    end
    if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
      return {1'b0, imm, 5'd0, 3'b000, c[11:7], 7'h13};
    end
    if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && c[6:2] != 5'd0) begin
      // bit 12 picks c.add over c.mv
      return {1'b0, 7'h00, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], 7'h33};
    end
    return {1'b1, 16'h0000, c};
  endfunction

  // misaligned targets alternate between a 32-bit and a 16-bit start
  function automatic addr_t pick_target(input int n);
    addr_t a;
    half_t h;
    int k;
    logic want32;
    a = rand_bits(6) << 2;
    if (n % 2 == 1) begin
      want32 = (n % 4 == 1);
      a = a + 2;
      h = half_at(a);
      k = 0;
      while (k < IMG_WORDS && ((h[1:0] == 2'b11) != want32)) begin
        a = a + 4;
        h = half_at(a);
        k++;
      end
    end
    return a;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [71:0] expected,
                             input logic [71:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("error %s %s expected %h actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  // mix of 32-bit, supported and unsupported compressed parcels
  task automatic build_image();
    half_t h [2*IMG_WORDS];
    logic [2:0] kind;
    logic [31:0] r;
    int i;
    i = 0;
    while (i < 2*IMG_WORDS) begin
      kind = rand_bits(3);
      r = rand_bits(30);
      if (kind < 3 && i < 2*IMG_WORDS - 1) begin
        h[i] = {r[13:0], 2'b11};
        h[i+1] = r[29:14];
        i += 2;
      end else begin
        case (kind)
          3'd3: h[i] = r[11] ? 16'h0001 : {3'b000, r[10:0], 2'b01};
          3'd4: h[i] = {3'b010, r[10:0], 2'b01};
          3'd5: h[i] = {3'b100, r[10:5], r[4:1], 1'b1, 2'b10};
          3'd6: h[i] = {r[13:0], 2'b00};
          // c.bnez, outside the supported set
          default: h[i] = {3'b111, r[10:0], 2'b01};
        endcase
        i += 1;
      end
    end
    for (i = 0; i < IMG_WORDS; i++) begin
      image[i] = {h[2*i+1], h[2*i]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory side and decode side drivers
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      branch_i    <= 1'b0;
      mem_valid_i <= 1'b0;
      case (bp_mode)
        2'd0:    id_valid_i <= 1'b1;
        2'd1:    id_valid_i <= (rand_bits(2) != 0);
        default: id_valid_i <= 1'b0;
      endcase
      if (branch_req) begin
        branch_i      <= 1'b1;
        branch_addr_i <= branch_tgt;
        fetch_addr    = {branch_tgt[31:2], 2'b00};
        branch_req    = 1'b0;
      end else if (run_mem && !stall_s && !mem_valid_i && rand_bits(2) != 0) begin
        // one free strobe every other cycle at most keeps clear of a full buffer
        mem_valid_i <= 1'b1;
        mem_data_i  <= image[fetch_addr[7:2]];
        fetch_addr  = fetch_addr + 4;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and output checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    half_t       lo;
    logic [32:0] exp_c;
    instr_out_t  exp_o;
    addr_t       head_addr;
    addr_t       fill_end;
    if (rst_n) begin
      stall_s = fetch_stall_o;
      if (fill_check) begin
        // a half-used word has already left the buffer
        head_addr = {model_pc[31:2], 2'b00} + (model_pc[1] ? 32'd4 : 32'd0);
        // a strobe still in flight lands at the next edge
        fill_end  = mem_valid_i ? fetch_addr - 4 : fetch_addr;
        check_value("stall level",
                    72'((fill_end - head_addr) == addr_t'(FIFO_DEPTH * 4)),
                    fetch_stall_o);
      end
      if (branch_i) begin
        check_value("valid in branch cycle", 72'd0, instr_valid_o);
        model_pc = branch_addr_i;
      end
      // a stalled instruction must stay put
      if (prev_hold && !branch_i) begin
        check_value("held valid", 72'd1, instr_valid_o);
        check_value("held output", prev_out, instr_o);
      end
      prev_hold = instr_valid_o && !id_valid_i;
      prev_out  = instr_o;
      if (instr_valid_o && id_valid_i) begin
        lo = half_at(model_pc);
        exp_o.pc = model_pc;
        if (lo[1:0] == 2'b11) begin
          exp_o.instr      = {half_at(model_pc + 2), lo};
          exp_o.compressed = 1'b0;
          exp_o.illegal    = 1'b0;
          model_pc         = model_pc + 4;
        end else begin
          exp_c            = expand(lo);
          exp_o.instr      = exp_c[31:0];
          exp_o.compressed = 1'b1;
          exp_o.illegal    = exp_c[32];
          model_pc         = model_pc + 2;
          n_illegal        += exp_c[32];
          n_legal          += !exp_c[32];
        end
        check_value("instruction", exp_o, instr_o);
        accepted++;
      end
    end
  end

  // accepted is written at negedge, read here at posedge
  task automatic wait_accepted(input int n);
    int target;
    int t;
    target = accepted + n;
    t = 0;
    while (accepted < target) begin
      @(posedge clk);
      t++;
      if (t > 500) begin
        fail_run("timeout waiting for instructions to be accepted");
      end
    end
    @(negedge clk);
  endtask

  task automatic wait_stall();
    int t;
    t = 0;
    while (!fetch_stall_o) begin
      @(negedge clk);
      t++;
      if (t > 200) begin
        fail_run("timeout waiting for fetch stall with decode held off");
      end
    end
  endtask

  task automatic wait_branch();
    int t;
    t = 0;
    while (branch_req) begin
      @(negedge clk);
      t++;
      if (t > 20) begin
        fail_run("timeout waiting for the branch to be issued");
      end
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    mem_valid_i   = 1'b0;
    mem_data_i    = '0;
    id_valid_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    lfsr          = 32'd65;
    run_mem       = 1'b0;
    bp_mode       = 2'd0;
    branch_req    = 1'b0;
    fetch_addr    = '0;
    model_pc      = '0;
    stall_s       = 1'b0;
    fill_check    = 1'b1;
    prev_hold     = 1'b0;
    accepted      = 0;
    n_legal       = 0;
    n_illegal     = 0;
    build_image();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // quiet until the first word arrives
    test_name = "reset";
    repeat (3) begin
      @(negedge clk);
      check_value("valid", 72'd0, instr_valid_o);
      check_value("stall", 72'd0, fetch_stall_o);
    end

    test_name = "mixed";
    run_mem = 1'b1;
    wait_accepted(40);

    test_name = "backpressure";
    bp_mode = 2'd1;
    wait_accepted(40);
    bp_mode = 2'd2;
    wait_stall();
    repeat (6) begin
      @(negedge clk);
      check_value("stall while full", 72'd1, fetch_stall_o);
    end
    bp_mode = 2'd1;
    wait_accepted(20);

    test_name = "branch";
    fill_check = 1'b0;
    for (int n = 0; n < 16; n++) begin
      branch_tgt = pick_target(n);
      branch_req = 1'b1;
      wait_branch();
      wait_accepted(6);
    end

    if (n_legal == 0 || n_illegal == 0) begin
      fail_run("expansion was not exercised with both supported and unsupported parcels");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* verilog.f */
hw/fetch_pkg.sv
hw/fetch_fifo.sv
hw/instr_aligner.sv
hw/rvc_expander.sv
hw/fetch_align_top.sv
tests/tb_fetch_align.sv

/* Bender.yml */
package:
  name: fetch_align

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_fifo.sv
  - hw/instr_aligner.sv
  - hw/rvc_expander.sv
  - hw/fetch_align_top.sv
  - target: test
    files:
      - tests/tb_fetch_align.sv
